/* lbc_pkg.sv */
package lbc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [1:0]  size_t;
  typedef logic [3:0]  sel_t;
  typedef logic [1:0]  beat_t;

  localparam int LINE_BEATS = 4;
  localparam int WB_DEPTH   = 4;
  localparam int WB_TIMEOUT = 16;

  // Derived widths
  localparam int WB_PTR_W = $clog2(WB_DEPTH);
  localparam int WB_CNT_W = $clog2(WB_DEPTH + 1);
  localparam int TMR_W    = $clog2(WB_TIMEOUT);
  localparam int LINE_LSB = $clog2(LINE_BEATS) + 2;

  // Access size codes
  localparam size_t SZ_BYTE = 2'd0;
  localparam size_t SZ_HALF = 2'd1;
  localparam size_t SZ_WORD = 2'd2;

  // Current bus owner
  typedef enum logic [1:0] {
    SRC_NONE,
    SRC_IFETCH,
    SRC_DREAD,
    SRC_WRITE
  } src_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_DONE
  } seq_state_e;

endpackage

/* lbc_write_buffer.sv */
module lbc_write_buffer
  import lbc_pkg::*;
(
  input  logic  BUSCLK,
  input  logic  arst_n,
  input  logic  push,
  input  addr_t push_addr,
  input  data_t push_data,
  input  size_t push_sz,
  input  logic  pop,
  input  addr_t cmp_addr,
  output addr_t head_addr,
  output data_t head_data,
  output size_t head_sz,
  output logic  wr_pending,
  output logic  wr_full,
  output logic  rd_hit
);

  addr_t               addr_mem [WB_DEPTH];
  data_t               data_mem [WB_DEPTH];
  size_t               sz_mem   [WB_DEPTH];
  logic [WB_DEPTH-1:0] valid;
  logic [WB_PTR_W-1:0] wr_ptr;
  logic [WB_PTR_W-1:0] rd_ptr;
  logic [WB_CNT_W-1:0] count;

  always_ff @(posedge BUSCLK)
  begin
    if (push)
    begin
      addr_mem[wr_ptr] <= push_addr;
      data_mem[wr_ptr] <= push_data;
      sz_mem[wr_ptr]   <= push_sz;
    end
  end

  always_ff @(posedge BUSCLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr        <= wr_ptr + 1'b1;
        valid[wr_ptr] <= 1'b1;
      end
      if (pop)
      begin
        rd_ptr        <= rd_ptr + 1'b1;
        valid[rd_ptr] <= 1'b0;
      end
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // Oldest entry drains first
  assign head_addr  = addr_mem[rd_ptr];
  assign head_data  = data_mem[rd_ptr];
  assign head_sz    = sz_mem[rd_ptr];
  assign wr_pending = (count != '0);
  assign wr_full    = (count == WB_CNT_W'(WB_DEPTH));

  // Line granular match, a refill returns every word of the line
  always_comb
  begin
    rd_hit = 1'b0;
    for (int i = 0; i < WB_DEPTH; i++)
    begin
      if (valid[i] && (addr_mem[i][31:LINE_LSB] == cmp_addr[31:LINE_LSB]))
        rd_hit = 1'b1;
    end
  end

endmodule

/* lbc_req_path.sv */
module lbc_req_path
  import lbc_pkg::*;
(
  input  logic  BUSCLK,
  input  logic  arst_n,
  input  logic  i_req,
  input  addr_t i_addr,
  input  logic  i_uc,
  input  logic  d_rd,
  input  addr_t d_addr,
  input  size_t d_sz,
  input  logic  d_uc,
  input  src_e  src,
  input  logic  start,
  input  beat_t beat,
  input  addr_t head_addr,
  input  data_t head_data,
  input  size_t head_sz,
  input  logic  wb_ack,
  input  data_t wb_dat_r,
  input  logic  finish,
  output logic  i_pend,
  output logic  d_pend,
  output logic  line,
  output addr_t rd_addr,
  output addr_t wb_adr,
  output sel_t  wb_sel,
  output logic  wb_we,
  output data_t wb_dat_w,
  output data_t rd_data,
  output logic  i_val,
  output logic  d_val
);

  addr_t i_addr_q;
  logic  i_uc_q;
  addr_t d_addr_q;
  size_t d_sz_q;
  logic  d_uc_q;
  logic  rd_open;

  function automatic sel_t lane_sel(addr_t a, size_t sz);
    case (sz)
      SZ_BYTE: lane_sel = sel_t'(4'b0001 << a[1:0]);
      SZ_HALF: lane_sel = a[1] ? 4'b1100 : 4'b0011;
      default: lane_sel = 4'b1111;
    endcase
  endfunction

  // CPU supplies write data in the low bits, copy it to every lane
  function automatic data_t lane_data(data_t d, size_t sz);
    case (sz)
      SZ_BYTE: lane_data = {4{d[7:0]}};
      SZ_HALF: lane_data = {2{d[15:0]}};
      default: lane_data = d;
    endcase
  endfunction

  function automatic addr_t bus_addr(addr_t a, logic is_line, beat_t b);
    if (is_line)
      bus_addr = {a[31:LINE_LSB], b, 2'b00};
    else
      bus_addr = {a[31:2], 2'b00};
  endfunction

  always_ff @(posedge BUSCLK)
  begin
    if (i_req)
    begin
      i_addr_q <= i_addr;
      i_uc_q   <= i_uc;
    end
    if (d_rd)
    begin
      d_addr_q <= d_addr;
      d_sz_q   <= d_sz;
      d_uc_q   <= d_uc;
    end
    if (rd_open && wb_ack && !wb_we)
      rd_data <= wb_dat_r;
  end

  // A new request in the finishing cycle wins over the clear
  always_ff @(posedge BUSCLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      i_pend  <= 1'b0;
      d_pend  <= 1'b0;
      rd_open <= 1'b0;
      i_val   <= 1'b0;
      d_val   <= 1'b0;
    end
    else
    begin
      if (finish && (src == SRC_IFETCH))
        i_pend <= 1'b0;
      if (i_req)
        i_pend <= 1'b1;
      if (finish && (src == SRC_DREAD))
        d_pend <= 1'b0;
      if (d_rd)
        d_pend <= 1'b1;
      if (start)
        rd_open <= 1'b1;
      else if (finish)
        rd_open <= 1'b0;
      i_val <= rd_open && wb_ack && (src == SRC_IFETCH);
      d_val <= rd_open && wb_ack && (src == SRC_DREAD);
    end
  end

  assign rd_addr = d_addr_q;

  always_comb
  begin
    line     = 1'b0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_we    = 1'b0;
    wb_dat_w = '0;
    case (src)
      SRC_IFETCH:
      begin
        line   = !i_uc_q;
        wb_adr = bus_addr(i_addr_q, line, beat);
        wb_sel = '1;
      end
      SRC_DREAD:
      begin
        line   = !d_uc_q;
        wb_adr = bus_addr(d_addr_q, line, beat);
        // Uncached reads only enable the addressed lanes
        wb_sel = line ? sel_t'('1) : lane_sel(d_addr_q, d_sz_q);
      end
      SRC_WRITE:
      begin
        wb_adr   = bus_addr(head_addr, 1'b0, beat);
        wb_sel   = lane_sel(head_addr, head_sz);
        wb_we    = 1'b1;
        wb_dat_w = lane_data(head_data, head_sz);
      end
      default:
      begin
        line = 1'b0;
      end
    endcase
  end

endmodule

/* lbc_bus_timer.sv */
module lbc_bus_timer
  import lbc_pkg::*;
(
  input  logic  BUSCLK,
  input  logic  arst_n,
  input  logic  start,
  input  logic  bus_active,
  input  logic  wb_ack,
  input  logic  line,
  output beat_t beat,
  output logic  last,
  output logic  timeout
);

  logic [TMR_W-1:0] wait_cnt;

  always_ff @(posedge BUSCLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      beat     <= '0;
      wait_cnt <= '0;
    end
    else if (start)
    begin
      beat     <= '0;
      wait_cnt <= '0;
    end
    else if (bus_active)
    begin
      if (wb_ack)
      begin
        beat     <= beat + 1'b1;
        wait_cnt <= '0;
      end
      else
        wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign last = line ? (beat == beat_t'(LINE_BEATS - 1)) : (beat == '0);

  // An acknowledge in the final cycle still counts
  assign timeout = bus_active && !wb_ack && (wait_cnt == TMR_W'(WB_TIMEOUT - 1));

endmodule

/* lbc_seq.sv */
module lbc_seq
  import lbc_pkg::*;
(
  input  logic BUSCLK,
  input  logic arst_n,
  input  logic i_pend,
  input  logic d_pend,
  input  logic rd_hit,
  input  logic wr_pending,
  input  logic wb_ack,
  input  logic last,
  input  logic timeout,
  output src_e src,
  output logic start,
  output logic bus_active,
  output logic finish,
  output logic wb_cyc,
  output logic wb_stb,
  output logic i_done,
  output logic d_done,
  output logic bus_err,
  output logic wr_err
);

  seq_state_e state;
  src_e       src_nxt;
  logic       err_q;

  // Fixed priority, older writes to the read line drain first
  always_comb
  begin
    src_nxt = SRC_NONE;
    if (d_pend && rd_hit && wr_pending)
      src_nxt = SRC_WRITE;
    else if (i_pend)
      src_nxt = SRC_IFETCH;
    else if (d_pend)
      src_nxt = SRC_DREAD;
    else if (wr_pending)
      src_nxt = SRC_WRITE;
  end

  assign start      = (state == ST_IDLE) && (src_nxt != SRC_NONE);
  assign bus_active = (state == ST_BUS);
  assign wb_cyc     = bus_active;
  assign wb_stb     = bus_active;
  assign finish     = (state == ST_DONE);

  // Done aligns with the registered val of the last beat
  assign i_done  = finish && (src == SRC_IFETCH);
  assign d_done  = finish && (src == SRC_DREAD);
  assign bus_err = finish && err_q && (src != SRC_WRITE);
  assign wr_err  = finish && err_q && (src == SRC_WRITE);

  always_ff @(posedge BUSCLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= ST_IDLE;
      src   <= SRC_NONE;
      err_q <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (start)
          begin
            state <= ST_BUS;
            src   <= src_nxt;
            err_q <= 1'b0;
          end
        end
        ST_BUS:
        begin
          if (wb_ack && last)
            state <= ST_DONE;
          else if (timeout)
          begin
            state <= ST_DONE;
            err_q <= 1'b1;
          end
        end
        ST_DONE:
        begin
          state <= ST_IDLE;
          src   <= SRC_NONE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* lbc_top.sv */
module lbc_top
  import lbc_pkg::*;
(
  input  logic  BUSCLK,
  input  logic  arst_n,
  input  logic  i_req,
  input  addr_t i_addr,
  input  logic  i_uc,
  output logic  i_val,
  output logic  i_done,
  output data_t rd_data,
  output logic  bus_err,
  input  logic  d_rd,
  input  addr_t d_addr,
  input  size_t d_sz,
  input  logic  d_uc,
  output logic  d_val,
  output logic  d_done,
  input  logic  d_wr,
  input  data_t d_wdata,
  output logic  wr_full,
  output logic  wr_err,
  output logic  wb_cyc,
  output logic  wb_stb,
  output logic  wb_we,
  output addr_t wb_adr,
  output sel_t  wb_sel,
  output data_t wb_dat_w,
  input  data_t wb_dat_r,
  input  logic  wb_ack
);

  src_e  src;
  logic  start;
  logic  bus_active;
  logic  finish;
  logic  i_pend;
  logic  d_pend;
  logic  line;
  addr_t rd_addr;
  logic  wr_pending;
  logic  rd_hit;
  logic  pop;
  addr_t head_addr;
  data_t head_data;
  size_t head_sz;
  beat_t beat;
  logic  last;
  logic  timeout;

  // Write entry leaves on its acknowledge or is dropped on timeout
  assign pop = (src == SRC_WRITE) && ((wb_cyc && wb_ack) || timeout);

  lbc_write_buffer u_write_buffer (
    .BUSCLK     (BUSCLK),
    .arst_n     (arst_n),
    .push       (d_wr),
    .push_addr  (d_addr),
    .push_data  (d_wdata),
    .push_sz    (d_sz),
    .pop        (pop),
    .cmp_addr   (rd_addr),
    .head_addr  (head_addr),
    .head_data  (head_data),
    .head_sz    (head_sz),
    .wr_pending (wr_pending),
    .wr_full    (wr_full),
    .rd_hit     (rd_hit)
  );

  lbc_req_path u_req_path (
    .BUSCLK    (BUSCLK),
    .arst_n    (arst_n),
    .i_req     (i_req),
    .i_addr    (i_addr),
    .i_uc      (i_uc),
    .d_rd      (d_rd),
    .d_addr    (d_addr),
    .d_sz      (d_sz),
    .d_uc      (d_uc),
    .src       (src),
    .start     (start),
    .beat      (beat),
    .head_addr (head_addr),
    .head_data (head_data),
    .head_sz   (head_sz),
    .wb_ack    (wb_ack),
    .wb_dat_r  (wb_dat_r),
    .finish    (finish),
    .i_pend    (i_pend),
    .d_pend    (d_pend),
    .line      (line),
    .rd_addr   (rd_addr),
    .wb_adr    (wb_adr),
    .wb_sel    (wb_sel),
    .wb_we     (wb_we),
    .wb_dat_w  (wb_dat_w),
    .rd_data   (rd_data),
    .i_val     (i_val),
    .d_val     (d_val)
  );

  lbc_bus_timer u_bus_timer (
    .BUSCLK     (BUSCLK),
    .arst_n     (arst_n),
    .start      (start),
    .bus_active (bus_active),
    .wb_ack     (wb_ack),
    .line       (line),
    .beat       (beat),
    .last       (last),
    .timeout    (timeout)
  );

  lbc_seq u_seq (
    .BUSCLK     (BUSCLK),
    .arst_n     (arst_n),
    .i_pend     (i_pend),
    .d_pend     (d_pend),
    .rd_hit     (rd_hit),
    .wr_pending (wr_pending),
    .wb_ack     (wb_ack),
    .last       (last),
    .timeout    (timeout),
    .src        (src),
    .start      (start),
    .bus_active (bus_active),
    .finish     (finish),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .i_done     (i_done),
    .d_done     (d_done),
    .bus_err    (bus_err),
    .wr_err     (wr_err)
  );

endmodule

/* tb_lbc_asserts.sv */
module tb_lbc_asserts
  import lbc_pkg::*;
(
  input logic  BUSCLK,
  input logic  arst_n,
  input logic  wb_cyc,
  input logic  wb_stb,
  input logic  wb_we,
  input addr_t wb_adr,
  input sel_t  wb_sel,
  input logic  wb_ack,
  input logic  i_val,
  input logic  d_val,
  input logic  i_done,
  input logic  d_done
);

  int fails = 0;

  // Strobe drops with the cycle and the bus then rests for a clock
  a_cyc_gap: assert property (@(posedge BUSCLK) disable iff (!arst_n)
    $fell(wb_cyc) |-> !wb_stb ##1 (!wb_cyc && !wb_stb))
  else
  begin
    $error("wb_stb outside a bus cycle or no idle clock between cycles");
    fails++;
  end

  // A waiting strobe holds its request until acknowledged or dropped
  a_req_stable: assert property (@(posedge BUSCLK) disable iff (!arst_n)
    (wb_stb && !wb_ack) |=> (!wb_stb || ($stable(wb_adr) && $stable(wb_sel) && $stable(wb_we))))
  else
  begin
    $error("Wishbone request changed while waiting for wb_ack");
    fails++;
  end

  // Only one CPU side receives a return in any cycle
  a_one_side: assert property (@(posedge BUSCLK) disable iff (!arst_n)
    !((i_val || i_done) && (d_val || d_done)))
  else
  begin
    $error("fetch side and data side returned in the same cycle");
    fails++;
  end

endmodule

bind lbc_top tb_lbc_asserts u_asserts (
  .BUSCLK (BUSCLK),
  .arst_n (arst_n),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_we  (wb_we),
  .wb_adr (wb_adr),
  .wb_sel (wb_sel),
  .wb_ack (wb_ack),
  .i_val  (i_val),
  .d_val  (d_val),
  .i_done (i_done),
  .d_done (d_done)
);

/* tb_lbc_checker.sv */
module tb_lbc_checker
  import lbc_pkg::*;
(
  input logic  BUSCLK,
  input logic  i_val,
  input logic  d_val,
  input logic  i_done,
  input logic  d_done,
  input data_t rd_data,
  input logic  bus_err,
  input logic  wr_err
);

  data_t exp_q [$];
  logic  exp_side = 1'b0;
  logic  exp_err  = 1'b0;
  logic  exp_open = 1'b0;
  int    checks   = 0;
  int    errors   = 0;
  int    wr_errs  = 0;

  task automatic expect_word(data_t w);
    exp_q.push_back(w);
  endtask

  // Side 1 is the data read port and side 0 the fetch port
  task automatic expect_end(logic side_d, logic err);
    exp_side = side_d;
    exp_err  = err;
    exp_open = 1'b1;
  endtask

  task automatic report_failure(string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_value(string name, data_t expected, data_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // Registered outputs are settled at the falling edge
  always @(negedge BUSCLK)
  begin
    if (i_val || d_val)
    begin
      if (exp_q.size() == 0)
        report_failure("read data returned while no word was expected");
      else
      begin
        check_flag("d_val", exp_side, d_val);
        check_flag("i_val", !exp_side, i_val);
        check_value("rd_data", exp_q.pop_front(), rd_data);
      end
    end
    if (bus_err && !(i_done || d_done))
      report_failure("bus_err raised without a done pulse");
    if (i_done || d_done)
    begin
      if (!exp_open)
        report_failure("done pulse without an outstanding read");
      else
      begin
        check_flag("d_done", exp_side, d_done);
        check_flag("i_done", !exp_side, i_done);
        check_flag("bus_err", exp_err, bus_err);
        check_flag("i_val|d_val", !exp_err, i_val || d_val);
        if (exp_q.size() != 0)
          report_failure("done arrived before all words were returned");
        exp_q.delete();
        exp_open = 1'b0;
      end
    end
    if (wr_err)
      wr_errs++;
  end

endmodule

/* tb_lbc.sv */
module tb_lbc
  import lbc_pkg::*;
();

  localparam int LIMIT = 64;

  logic  BUSCLK = 1'b0;
  logic  arst_n;
  logic  i_req;
  addr_t i_addr;
  logic  i_uc;
  logic  i_val;
  logic  i_done;
  data_t rd_data;
  logic  bus_err;
  logic  d_rd;
  addr_t d_addr;
  size_t d_sz;
  logic  d_uc;
  logic  d_val;
  logic  d_done;
  logic  d_wr;
  data_t d_wdata;
  logic  wr_full;
  logic  wr_err;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  addr_t wb_adr;
  sel_t  wb_sel;
  data_t wb_dat_w;
  data_t wb_dat_r;
  logic  wb_ack;

  data_t       mem    [256];
  data_t       shadow [256];
  logic        stall;
  logic        waiting;
  int          wait_left;
  int          slot;
  int          mark;
  int          total;

  lbc_top u_lbc_top (.*);

  tb_lbc_checker u_checker (.*);

  always #2 BUSCLK = ~BUSCLK;

  function automatic data_t fill_word(int idx);
    return data_t'(idx) * 32'h9E37_79B1 + 32'h0101_0101;
  endfunction

  // Shadow memory sees every write in push order
  function automatic void apply_write(addr_t a, data_t d, size_t sz);
    int idx;
    int lane;
    idx  = int'(a[9:2]);
    lane = int'(a[1:0]);
    if (a < 32'hF000_0000)
    begin
      case (sz)
        SZ_BYTE: shadow[idx][8*lane +: 8] = d[7:0];
        SZ_HALF: shadow[idx][16*(lane/2) +: 16] = d[15:0];
        default: shadow[idx] = d;
      endcase
    end
  endfunction

  function automatic data_t ref_read(addr_t a);
    return shadow[int'(a[9:2])];
  endfunction

  // Wishbone slave with random wait states that never answers above 0xF0000000
  initial
  begin
    wb_ack    = 1'b0;
    wb_dat_r  = '0;
    waiting   = 1'b0;
    wait_left = 0;
    for (int i = 0; i < 256; i++)
      mem[i] = fill_word(i);
    forever
    begin
      @(negedge BUSCLK);
      if (wb_ack || !wb_cyc)
      begin
        wb_ack  = 1'b0;
        waiting = 1'b0;
      end
      else if (wb_stb && !stall && (wb_adr < 32'hF000_0000))
      begin
        if (!waiting)
        begin
          wait_left = int'($urandom % 4);
          waiting   = 1'b1;
        end
        if (wait_left > 0)
          wait_left--;
        else
        begin
          slot = int'(wb_adr[9:2]);
          if (wb_we)
          begin
            for (int b = 0; b < 4; b++)
            begin
              if (wb_sel[b])
                mem[slot][8*b +: 8] = wb_dat_w[8*b +: 8];
            end
          end
          else
            wb_dat_r = mem[slot];
          wb_ack = 1'b1;
        end
      end
    end
  end

  task automatic push_write(addr_t a, data_t d, size_t sz);
    int n;
    n = 0;
    while (wr_full && (n < LIMIT))
    begin
      @(negedge BUSCLK);
      n++;
    end
    if (wr_full)
      u_checker.report_failure("write buffer stayed full, write not pushed");
    else
    begin
      d_wr    = 1'b1;
      d_addr  = a;
      d_wdata = d;
      d_sz    = sz;
      apply_write(a, d, sz);
      @(negedge BUSCLK);
      d_wr = 1'b0;
    end
  endtask

  task automatic issue_read(logic side_d, addr_t a, logic uc, size_t sz, logic err);
    int    n;
    int    beats;
    addr_t base;
    beats = uc ? 1 : LINE_BEATS;
    base  = uc ? {a[31:2], 2'b00} : (a & ~addr_t'(LINE_BEATS * 4 - 1));
    if (!err)
    begin
      for (int k = 0; k < beats; k++)
        u_checker.expect_word(ref_read(base + addr_t'(4 * k)));
    end
    u_checker.expect_end(side_d, err);
    if (side_d)
    begin
      d_rd   = 1'b1;
      d_addr = a;
      d_sz   = sz;
      d_uc   = uc;
    end
    else
    begin
      i_req  = 1'b1;
      i_addr = a;
      i_uc   = uc;
    end
    @(negedge BUSCLK);
    i_req = 1'b0;
    d_rd  = 1'b0;
    n = 0;
    while (!(i_done || d_done) && (n < LIMIT))
    begin
      @(negedge BUSCLK);
      n++;
    end
    if (!(i_done || d_done))
      u_checker.report_failure("read never finished, no done pulse");
    @(negedge BUSCLK);
  endtask

  task automatic end_test(string name, int start_errors);
    if (u_checker.errors == start_errors)
      $display("Test %s: ok", name);
    else
      $display("Test %s: %0d error(s)", name, u_checker.errors - start_errors);
  endtask

  initial
  begin
    void'($urandom(39733));
    arst_n   = 1'b0;
    i_req    = 1'b0;
    i_addr   = '0;
    i_uc     = 1'b0;
    d_rd     = 1'b0;
    d_addr   = '0;
    d_sz     = SZ_WORD;
    d_uc     = 1'b0;
    d_wr     = 1'b0;
    d_wdata  = '0;
    stall   <= 1'b0;
    for (int i = 0; i < 256; i++)
      shadow[i] = fill_word(i);
    repeat (2) @(posedge BUSCLK);
    @(negedge BUSCLK);
    arst_n = 1'b1;
    @(negedge BUSCLK);

    mark = u_checker.errors;
    issue_read(1'b0, 32'h0000_0034, 1'b0, SZ_WORD, 1'b0);
    end_test("1 cached fetch", mark);

    mark = u_checker.errors;
    issue_read(1'b1, 32'h0000_0021, 1'b1, SZ_BYTE, 1'b0);
    issue_read(1'b1, 32'h0000_0026, 1'b1, SZ_HALF, 1'b0);
    issue_read(1'b1, 32'h0000_0028, 1'b1, SZ_WORD, 1'b0);
    end_test("2 uncached data reads", mark);

    // Line read follows the writes at once and has to wait for the drain
    mark = u_checker.errors;
    push_write(32'h0000_0081, 32'h0000_00AB, SZ_BYTE);
    push_write(32'h0000_0086, 32'h0000_1234, SZ_HALF);
    push_write(32'h0000_0088, 32'hDEAD_BEEF, SZ_WORD);
    issue_read(1'b1, 32'h0000_0084, 1'b0, SZ_WORD, 1'b0);
    issue_read(1'b1, 32'h0000_0081, 1'b1, SZ_BYTE, 1'b0);
    issue_read(1'b1, 32'h0000_0086, 1'b1, SZ_HALF, 1'b0);
    end_test("3 merged writes", mark);

    mark = u_checker.errors;
    stall <= 1'b1;
    for (int k = 0; k < WB_DEPTH; k++)
    begin
      push_write(32'h0000_0100 + addr_t'(4 * k), fill_word(k + 900), SZ_WORD);
      if (k == WB_DEPTH - 2)
        u_checker.check_flag("wr_full", 1'b0, wr_full);
    end
    u_checker.check_flag("wr_full", 1'b1, wr_full);
    stall <= 1'b0;
    push_write(32'h0000_0110, 32'h5555_AAAA, SZ_WORD);
    issue_read(1'b1, 32'h0000_0100, 1'b0, SZ_WORD, 1'b0);
    issue_read(1'b1, 32'h0000_0110, 1'b1, SZ_WORD, 1'b0);
    end_test("4 full write buffer", mark);

    mark = u_checker.errors;
    issue_read(1'b1, 32'hF000_0000, 1'b1, SZ_WORD, 1'b1);
    push_write(32'hF000_0008, 32'h0BAD_0BAD, SZ_WORD);
    total = 0;
    while (!wr_err && (total < LIMIT))
    begin
      @(negedge BUSCLK);
      total++;
    end
    if (!wr_err)
      u_checker.report_failure("write to a silent address never raised wr_err");
    @(negedge BUSCLK);
    issue_read(1'b0, 32'h0000_0010, 1'b1, SZ_WORD, 1'b0);
    issue_read(1'b1, 32'h0000_0054, 1'b0, SZ_WORD, 1'b0);
    u_checker.check_value("wr_err pulses", 32'd1, data_t'(u_checker.wr_errs));
    end_test("5 bus timeouts", mark);

    total = u_checker.errors + u_lbc_top.u_asserts.fails;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             u_checker.checks, u_checker.errors, u_lbc_top.u_asserts.fails);
    if (total == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* all.f */
lbc_pkg.sv
lbc_write_buffer.sv
lbc_req_path.sv
lbc_bus_timer.sv
lbc_seq.sv
lbc_top.sv
tb_lbc_asserts.sv
tb_lbc_checker.sv
tb_lbc.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert --timing
TOP      = tb_lbc
FILELIST = all.f
SIMARGS  = +verilator+error+limit+100

SOURCES  = $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: run clean

run: $(BIN)
	./$(BIN) $(SIMARGS) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
